// ==== bench/mp3_glue_tb.sv ====
`include "mp3_glue_defs.svh"

module mp3_glue_tb
	import mp3_glue_pkg::*;
();

	localparam int info_bits = $bits(frame_info_t);

	logic                       HUFF_clock;
	logic                       MAC_resetn;
	logic [`MP3_ADDR_WIDTH-1:0] huff_dpr_address;
	logic                       huff_done;
	frame_info_t                huff_info;
	granule_wr_t                granule_wr;
	logic                       fifo_ren;
	logic                       mac_ram_idle;
	logic                       mac_done;
	logic [`MP3_ADDR_WIDTH-1:0] ch0_pcm_wr_address;
	logic                       ch0_rd_en;
	logic [`MP3_ADDR_WIDTH-1:0] ch0_rd_addr;
	logic                       ch1_rd_en;
	logic [`MP3_ADDR_WIDTH-1:0] ch1_rd_addr;
	logic                       ch0_start;
	logic                       ch1_start;
	frame_info_t                mac_info;
	logic [`MP3_DATA_WIDTH-1:0] ch0_rd_data;
	logic [`MP3_DATA_WIDTH-1:0] ch1_rd_data;
	logic [`MP3_ADDR_WIDTH-1:0] pcm_rd_address;
	logic [3:0]                 hold_cycles;
	integer                     seed;
	logic                       fifo_check_on;
	// address seen at the last rising edge
	logic [`MP3_ADDR_WIDTH-1:0] prev_addr;
	// what mac_info should show
	frame_info_t                cur_info;
	// bench copy of both granule rams
	logic [`MP3_DATA_WIDTH-1:0] ram_model [0:1][0:`MP3_RAM_DEPTH-1];

	mp3_glue_top mp3_glue_top_inst (.*);

	mp3_glue_tb_mac_model mac_model_inst (.*);

	always #20 HUFF_clock = ~HUFF_clock;

	// ========================================
	// reference rules and checks
	// ========================================

	function automatic logic expected_fifo_ren(input logic [`MP3_ADDR_WIDTH-1:0] prev,
			input logic [`MP3_ADDR_WIDTH-1:0] cur);
		return prev[0] != cur[0];
	endfunction

	// channel 1 only for stereo and joint stereo
	function automatic logic expected_ch1_start(input channel_mode_e m);
		case (m)
			stereo, joint_stereo: return 1'b1;
			default: return 1'b0;
		endcase
	endfunction

	function automatic logic [`MP3_DATA_WIDTH-1:0] expected_word(input logic ch,
			input logic [`MP3_ADDR_WIDTH-1:0] a);
		return ram_model[ch][a];
	endfunction

	// whole address in the word and inverted for channel 1
	function automatic logic [`MP3_DATA_WIDTH-1:0] fill_word(input logic ch,
			input logic [`MP3_ADDR_WIDTH-1:0] a);
		return {a[5:0], a} ^ {`MP3_DATA_WIDTH{ch}};
	endfunction

	task automatic check(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		if (actual !== expected) begin
			$display("FAIL at %0t: %s is %0h, expected %0h", $time, name, actual, expected);
			$display("TB FAILED");
			$fatal(1, "value mismatch on %s", name);
		end
	endtask

	task automatic report_timeout(input string what);
		$display("timeout: %s", what);
		$display("TB FAILED");
		$fatal(1, "wait timed out");
	endtask

	// fifo strobe compare half a phase before the rising edge
	always @(negedge HUFF_clock) begin
		#10;
		if (fifo_check_on) begin
			check("fifo_ren", fifo_ren, expected_fifo_ren(prev_addr, huff_dpr_address));
		end
		prev_addr = huff_dpr_address;
	end

	// one huffman write into one channel
	task automatic write_word(input logic ch, input logic [`MP3_ADDR_WIDTH-1:0] a,
			input logic [`MP3_DATA_WIDTH-1:0] d);
		granule_wr.addr   = a;
		granule_wr.data   = d;
		granule_wr.we_ch0 = !ch;
		granule_wr.we_ch1 = ch;
		ram_model[ch][a]  = d;
		@(negedge HUFF_clock);
	endtask

	// rising huff_done with new info visible two edges later
	task automatic capture_info(input frame_info_t info);
		huff_done = 1'b0;
		@(negedge HUFF_clock);
		huff_info = info;
		huff_done = 1'b1;
		@(negedge HUFF_clock);
		check("mac_info", mac_info, cur_info);
		@(negedge HUFF_clock);
		check("mac_info", mac_info, info);
		cur_info = info;
	endtask

	// ========================================
	// test sequence
	// ========================================

	initial begin
		int i;
		int n;
		logic [`MP3_ADDR_WIDTH-1:0] a;
		logic [`MP3_ADDR_WIDTH-1:0] mark;
		logic [`MP3_DATA_WIDTH-1:0] held;
		logic [`MP3_ADDR_WIDTH-1:0] written [$];
		frame_info_t info;
		logic exp_ch1;
		seed = 89243;
		HUFF_clock = 1'b0;
		MAC_resetn = 1'b0;
		huff_dpr_address = '0;
		huff_done = 1'b0;
		huff_info = '0;
		granule_wr = '0;
		ch0_rd_en = 1'b0;
		ch0_rd_addr = '0;
		ch1_rd_en = 1'b0;
		ch1_rd_addr = '0;
		pcm_rd_address = '0;
		hold_cycles = '0;
		fifo_check_on = 1'b0;
		cur_info = '0;
		repeat (10) @(negedge HUFF_clock);
		MAC_resetn = 1'b1;
		fifo_check_on = 1'b1;
		check("ch0_start", ch0_start, 0);
		check("ch1_start", ch1_start, 0);
		check("mac_ram_idle", mac_ram_idle, 1);
		check("mac_info", mac_info, 0);

		// steps of 0 to 3 give both toggles and holds
		repeat (200) begin
			huff_dpr_address = huff_dpr_address + `MP3_ADDR_WIDTH'($random(seed) & 3);
			@(negedge HUFF_clock);
		end

		// ========================================
		// granule rams
		// ========================================

		for (i = 0; i < `MP3_RAM_DEPTH; i++) begin
			write_word(1'b0, `MP3_ADDR_WIDTH'(i), fill_word(1'b0, `MP3_ADDR_WIDTH'(i)));
			write_word(1'b1, `MP3_ADDR_WIDTH'(i), fill_word(1'b1, `MP3_ADDR_WIDTH'(i)));
		end
		// channels take turns and the other keeps its fill
		for (i = 0; i < 32; i++) begin
			a = `MP3_ADDR_WIDTH'($random(seed));
			written.push_back(a);
			write_word(i[0], a, `MP3_DATA_WIDTH'($random(seed)));
		end
		granule_wr.we_ch0 = 1'b0;
		granule_wr.we_ch1 = 1'b0;
		check("mac_ram_idle", mac_ram_idle, 1);
		ch0_rd_en = 1'b1;
		ch1_rd_en = 1'b1;
		foreach (written[k]) begin
			ch0_rd_addr = written[k];
			ch1_rd_addr = written[k];
			@(negedge HUFF_clock);
			check("ch0_rd_data", ch0_rd_data, expected_word(1'b0, written[k]));
			check("ch1_rd_data", ch1_rd_data, expected_word(1'b1, written[k]));
			check("mac_ram_idle", mac_ram_idle, 0);
		end
		held = ch0_rd_data;
		ch0_rd_en = 1'b0;
		ch1_rd_en = 1'b0;
		ch0_rd_addr = ch0_rd_addr + 1'b1;
		@(negedge HUFF_clock);
		check("mac_ram_idle", mac_ram_idle, 1);
		check("ch0_rd_data", ch0_rd_data, held);

		// ========================================
		// side info capture
		// ========================================

		info = info_bits'($random(seed));
		capture_info(info);
		// no new rising edge so mac_info holds
		huff_info = info_bits'($random(seed));
		repeat (3) begin
			@(negedge HUFF_clock);
			check("mac_info", mac_info, cur_info);
		end
		huff_done = 1'b0;
		huff_info = info_bits'($random(seed));
		repeat (3) begin
			@(negedge HUFF_clock);
			check("mac_info", mac_info, cur_info);
		end

		// ========================================
		// mac start scheduling
		// ========================================

		for (i = 0; i < 20; i++) begin
			a = `MP3_ADDR_WIDTH'($random(seed));
			if (a == `MP3_ADDR_WIDTH'(`MP3_PCM_START_MARK)) begin
				a = a + 1'b1;
			end
			pcm_rd_address = a;
			@(negedge HUFF_clock);
			check("ch0_start", ch0_start, 0);
		end
		pcm_rd_address = `MP3_ADDR_WIDTH'(`MP3_PCM_START_MARK);
		repeat (3) begin
			@(negedge HUFF_clock);
			check("ch0_start", ch0_start, 0);
		end
		mark = '0;
		// one granule per channel mode
		for (i = 0; i < 4; i++) begin
			info = info_bits'($random(seed));
			info.mode = channel_mode_e'(i);
			capture_info(info);
			exp_ch1 = expected_ch1_start(info.mode);
			hold_cycles = 4'($random(seed));
			pcm_rd_address = mark + 2'd3;
			repeat (3) begin
				@(negedge HUFF_clock);
				check("ch0_start", ch0_start, 0);
			end
			pcm_rd_address = mark;
			n = 0;
			while (!ch0_start) begin
				if (n == 20) begin
					report_timeout("no mac start after playback reached the mark");
				end else begin
					@(negedge HUFF_clock);
					n++;
				end
			end
			// start held until the model drops done
			n = 0;
			while (mac_done) begin
				check("ch0_start", ch0_start, 1);
				check("ch1_start", ch1_start, exp_ch1);
				if (n == 40) begin
					report_timeout("mac model never dropped done");
				end else begin
					@(negedge HUFF_clock);
					n++;
				end
			end
			check("ch0_start", ch0_start, 0);
			check("ch1_start", ch1_start, 0);
			mark = ch0_pcm_wr_address;
			n = 0;
			while (!mac_done) begin
				check("ch0_start", ch0_start, 0);
				if (n == 40) begin
					report_timeout("mac model never raised done again");
				end else begin
					@(negedge HUFF_clock);
					n++;
				end
			end
		end

		$display("TB PASSED");
		$finish;
	end

endmodule

// ==== bench/mp3_glue_tb_mac_model.sv ====
`include "mp3_glue_defs.svh"

module mp3_glue_tb_mac_model (
	input  logic                       HUFF_clock,
	input  logic                       MAC_resetn,
	input  logic                       ch0_start,
	input  logic [3:0]                 hold_cycles,
	output logic                       mac_done,
	output logic [`MP3_ADDR_WIDTH-1:0] ch0_pcm_wr_address
);

	// write pointer advance per granule
	localparam logic [`MP3_ADDR_WIDTH-1:0] wr_step = `MP3_ADDR_WIDTH'(97);
	// cycles of synthesis work with done low
	localparam int busy_cycles = 5;

	int count;

	// driven on the falling edge like the rest of the bench
	always @(negedge HUFF_clock or negedge MAC_resetn) begin
		if (!MAC_resetn) begin
			mac_done           <= 1'b1;
			ch0_pcm_wr_address <= '0;
			count              <= 0;
		end else if (mac_done) begin
			// slow mac, leaves start pending for hold_cycles
			if (ch0_start) begin
				if (count >= int'(hold_cycles)) begin
					mac_done           <= 1'b0;
					ch0_pcm_wr_address <= ch0_pcm_wr_address + wr_step;
					count              <= 0;
				end else begin
					count <= count + 1;
				end
			end
		end else if (count >= busy_cycles) begin
			mac_done <= 1'b1;
			count    <= 0;
		end else begin
			count <= count + 1;
		end
	end

endmodule

// ==== list.f ====
+incdir+logic
logic/mp3_glue_pkg.sv
logic/granule_ram.sv
logic/huff_port_sync.sv
logic/granule_info_latch.sv
logic/mac_scheduler.sv
logic/mp3_glue_top.sv
bench/mp3_glue_tb_mac_model.sv
bench/mp3_glue_tb.sv

// ==== logic/granule_info_latch.sv ====
module granule_info_latch
	import mp3_glue_pkg::*;
(
	input  logic        HUFF_clock,
	input  logic        MAC_resetn,
	input  logic        huff_done,
	input  frame_info_t huff_info,
	output frame_info_t mac_info
);

	// previous huff_done
	logic        done_q;
	// granule end seen this cycle
	logic        done_rise;
	// huffman side capture stage
	frame_info_t capture_q;

	// ========================================
	// granule end detect
	// ========================================

	always_ff @(posedge HUFF_clock or negedge MAC_resetn) begin
		if (!MAC_resetn) begin
			done_q <= 1'b0;
		end else begin
			done_q <= huff_done;
		end
	end

	// low to high of the done level
	assign done_rise = huff_done && !done_q;

	// ========================================
	// two stage capture
	// ========================================

	// stage one, only on granule end
	always_ff @(posedge HUFF_clock or negedge MAC_resetn) begin
		if (!MAC_resetn) begin
			capture_q <= '0;
		end else if (done_rise) begin
			capture_q <= huff_info;
		end
	end

	// stage two toward the mac, copies every cycle
	// zero after reset means stereo, long blocks
	always_ff @(posedge HUFF_clock or negedge MAC_resetn) begin
		if (!MAC_resetn) begin
			mac_info <= '0;
		end else begin
			mac_info <= capture_q;
		end
	end

endmodule

// ==== logic/granule_ram.sv ====
`include "mp3_glue_defs.svh"

module granule_ram (
	input  logic                       HUFF_clock,
	// huffman side
	input  logic                       wr_en,
	input  logic [`MP3_ADDR_WIDTH-1:0] wr_addr,
	input  logic [`MP3_DATA_WIDTH-1:0] wr_data,
	// mac side
	input  logic                       rd_en,
	input  logic [`MP3_ADDR_WIDTH-1:0] rd_addr,
	output logic [`MP3_DATA_WIDTH-1:0] rd_data
);

	// one granule of samples
	logic [`MP3_DATA_WIDTH-1:0] mem [0:`MP3_RAM_DEPTH-1];

	// ========================================
	// write port
	// ========================================

	always_ff @(posedge HUFF_clock) begin
		if (wr_en) begin
			mem[wr_addr] <= wr_data;
		end
	end

	// ========================================
	// read port
	// ========================================

	// registered output, holds while rd_en is low
	always_ff @(posedge HUFF_clock) begin
		if (rd_en) begin
			rd_data <= mem[rd_addr];
		end
	end

endmodule

// ==== logic/huff_port_sync.sv ====
`include "mp3_glue_defs.svh"

module huff_port_sync (
	input  logic                       HUFF_clock,
	input  logic                       MAC_resetn,
	input  logic [`MP3_ADDR_WIDTH-1:0] huff_dpr_address,
	input  logic                       ch0_rd_en,
	input  logic                       ch1_rd_en,
	output logic                       fifo_ren,
	output logic                       mac_ram_idle
);

	// last sampled address lsb
	logic addr_lsb_q;
	// mac read enables, one cycle late
	logic ch0_rd_en_q;
	logic ch1_rd_en_q;

	// ========================================
	// fifo read strobe
	// ========================================

	always_ff @(posedge HUFF_clock) begin
		addr_lsb_q <= huff_dpr_address[0];
	end

	// one word per lsb toggle, no back-pressure
	assign fifo_ren = huff_dpr_address[0] != addr_lsb_q;

	// ========================================
	// mac ram idle
	// ========================================

	always_ff @(posedge HUFF_clock or negedge MAC_resetn) begin
		if (!MAC_resetn) begin
			ch0_rd_en_q <= 1'b0;
			ch1_rd_en_q <= 1'b0;
		end else begin
			ch0_rd_en_q <= ch0_rd_en;
			ch1_rd_en_q <= ch1_rd_en;
		end
	end

	// idle when neither channel reads
	assign mac_ram_idle = !(ch0_rd_en_q || ch1_rd_en_q);

endmodule

// ==== logic/mac_scheduler.sv ====
`include "mp3_glue_defs.svh"

module mac_scheduler
	import mp3_glue_pkg::*;
(
	input  logic                       HUFF_clock,
	input  logic                       MAC_resetn,
	input  logic                       mac_done,
	input  channel_mode_e              mode,
	input  logic [`MP3_ADDR_WIDTH-1:0] pcm_rd_address,
	input  logic [`MP3_ADDR_WIDTH-1:0] ch0_pcm_wr_address,
	output logic                       ch0_start,
	output logic                       ch1_start
);

	sched_state_e               state;
	// playback read address, one cycle late
	logic [`MP3_ADDR_WIDTH-1:0] rd_addr_q;
	// address playback must reach before next start
	logic [`MP3_ADDR_WIDTH-1:0] mark;
	// playback has caught up with the mark
	logic                       caught_up;
	// channel 1 runs only for two coded channels
	logic                       two_channel;

	// ========================================
	// playback address compare
	// ========================================

	always_ff @(posedge HUFF_clock) begin
		rd_addr_q <= pcm_rd_address;
	end

	assign caught_up = rd_addr_q == mark;

	// dual channel and mono leave channel 1 idle
	assign two_channel = (mode == stereo) || (mode == joint_stereo);

	// ========================================
	// start fsm
	// ========================================

	always_ff @(posedge HUFF_clock or negedge MAC_resetn) begin
		if (!MAC_resetn) begin
			state     <= wait_first;
			mark      <= `MP3_PCM_START_MARK;
			ch0_start <= 1'b0;
			ch1_start <= 1'b0;
		end else begin
			case (state)
				wait_first: begin
					// first pass through the start mark
					if (mac_done && caught_up) begin
						mark  <= '0;
						state <= armed;
					end
				end
				armed: begin
					// starts are always low here
					// mac idle and playback at last written sample
					if (mac_done && caught_up) begin
						ch0_start <= 1'b1;
						ch1_start <= two_channel;
						state     <= running;
					end
				end
				running: begin
					// hold start until the mac drops done
					if (!mac_done) begin
						ch0_start <= 1'b0;
						ch1_start <= 1'b0;
						// next start waits for this write point
						mark      <= ch0_pcm_wr_address;
						state     <= armed;
					end
				end
				default: begin
					ch0_start <= 1'b0;
					ch1_start <= 1'b0;
					state     <= wait_first;
				end
			endcase
		end
	end

endmodule

// ==== logic/mp3_glue_defs.svh ====
`ifndef MP3_GLUE_DEFS_SVH
`define MP3_GLUE_DEFS_SVH

// ========================================
// glue widths and sizes
// ========================================

// granule ram and playback address width
`define MP3_ADDR_WIDTH 10

// one sample word
`define MP3_DATA_WIDTH 16

// words per granule ram
`define MP3_RAM_DEPTH 1024

// playback address the first mac start waits for
`define MP3_PCM_START_MARK 500

`endif

// ==== logic/mp3_glue_pkg.sv ====
`include "mp3_glue_defs.svh"

package mp3_glue_pkg;

	// ========================================
	// frame side information
	// ========================================

	// channel mode field from the frame header
	typedef enum logic [1:0] {
		stereo       = 2'd0,
		joint_stereo = 2'd1,
		dual_channel = 2'd2,
		mono         = 2'd3
	} channel_mode_e;

	// window block type of one channel
	typedef enum logic [1:0] {
		long_block  = 2'd0,
		start_block = 2'd1,
		short_block = 2'd2,
		stop_block  = 2'd3
	} block_type_e;

	// bit order as the huffman engine packs it, switching on top
	typedef struct packed {
		logic        switching;
		block_type_e block_type;
		logic        mixed;
	} granule_info_t;

	// mode plus both channels
	typedef struct packed {
		channel_mode_e mode;
		granule_info_t ch1;
		granule_info_t ch0;
	} frame_info_t;

	// mac start scheduler
	typedef enum logic [1:0] {
		wait_first = 2'd0,
		armed      = 2'd1,
		running    = 2'd2
	} sched_state_e;

	// one write from the huffman stage into the granule rams
	typedef struct packed {
		logic [`MP3_ADDR_WIDTH-1:0] addr;
		logic [`MP3_DATA_WIDTH-1:0] data;
		logic                       we_ch0;
		logic                       we_ch1;
	} granule_wr_t;

endpackage

// ==== logic/mp3_glue_top.sv ====
`include "mp3_glue_defs.svh"

module mp3_glue_top
	import mp3_glue_pkg::*;
(
	input  logic                       HUFF_clock,
	input  logic                       MAC_resetn,
	// huffman engine
	input  logic [`MP3_ADDR_WIDTH-1:0] huff_dpr_address,
	input  logic                       huff_done,
	input  frame_info_t                huff_info,
	input  granule_wr_t                granule_wr,
	output logic                       fifo_ren,
	output logic                       mac_ram_idle,
	// mac engine
	input  logic                       mac_done,
	input  logic [`MP3_ADDR_WIDTH-1:0] ch0_pcm_wr_address,
	input  logic                       ch0_rd_en,
	input  logic [`MP3_ADDR_WIDTH-1:0] ch0_rd_addr,
	input  logic                       ch1_rd_en,
	input  logic [`MP3_ADDR_WIDTH-1:0] ch1_rd_addr,
	output logic                       ch0_start,
	output logic                       ch1_start,
	output frame_info_t                mac_info,
	output logic [`MP3_DATA_WIDTH-1:0] ch0_rd_data,
	output logic [`MP3_DATA_WIDTH-1:0] ch1_rd_data,
	// playback
	input  logic [`MP3_ADDR_WIDTH-1:0] pcm_rd_address
);

	// ========================================
	// granule rams
	// ========================================

	// shared write bus, one enable per channel
	granule_ram ch0_ram (
		.HUFF_clock (HUFF_clock),
		.wr_en      (granule_wr.we_ch0),
		.wr_addr    (granule_wr.addr),
		.wr_data    (granule_wr.data),
		.rd_en      (ch0_rd_en),
		.rd_addr    (ch0_rd_addr),
		.rd_data    (ch0_rd_data)
	);

	granule_ram ch1_ram (
		.HUFF_clock (HUFF_clock),
		.wr_en      (granule_wr.we_ch1),
		.wr_addr    (granule_wr.addr),
		.wr_data    (granule_wr.data),
		.rd_en      (ch1_rd_en),
		.rd_addr    (ch1_rd_addr),
		.rd_data    (ch1_rd_data)
	);

	// ========================================
	// huffman handshakes
	// ========================================

	huff_port_sync huff_port_sync_inst (
		.HUFF_clock       (HUFF_clock),
		.MAC_resetn       (MAC_resetn),
		.huff_dpr_address (huff_dpr_address),
		.ch0_rd_en        (ch0_rd_en),
		.ch1_rd_en        (ch1_rd_en),
		.fifo_ren         (fifo_ren),
		.mac_ram_idle     (mac_ram_idle)
	);

	granule_info_latch granule_info_latch_inst (
		.HUFF_clock (HUFF_clock),
		.MAC_resetn (MAC_resetn),
		.huff_done  (huff_done),
		.huff_info  (huff_info),
		.mac_info   (mac_info)
	);

	// ========================================
	// mac start
	// ========================================

	// mode as the mac sees it, after capture
	mac_scheduler mac_scheduler_inst (
		.HUFF_clock         (HUFF_clock),
		.MAC_resetn         (MAC_resetn),
		.mac_done           (mac_done),
		.mode               (mac_info.mode),
		.pcm_rd_address     (pcm_rd_address),
		.ch0_pcm_wr_address (ch0_pcm_wr_address),
		.ch0_start          (ch0_start),
		.ch1_start          (ch1_start)
	);

endmodule

// ==== run.sh ====
#!/bin/sh
# build and run the glue testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary -Wno-fatal --top-module mp3_glue_tb -Mdir obj_dir -f list.f
status=$?
if [ "$status" -ne 0 ]; then
	echo "verilator build failed"
	exit "$status"
fi

./obj_dir/Vmp3_glue_tb
status=$?
if [ "$status" -ne 0 ]; then
	echo "simulation ended with status $status"
fi
exit "$status"
